// File: common/mmc3_pkg.sv
/* MMC3 shared types: CPU bus cycle, bank register groups, RAM and IRQ control,
   mapped address prefixes and the mirroring encoding */
package mmc3_pkg;

	localparam int PRG_BANK_W = 6;  // 8 KB PRG bank number
	localparam int CHR_BANK_W = 8;  // 1 KB CHR bank number
	localparam int MAP_ADDR_W = 22; // Mapped memory address

	// Regions of the mapped address space
	localparam logic [2:0] PRG_ROM_PREFIX = 3'b000;       // PRG ROM at the bottom
	localparam logic [2:0] CHR_ROM_PREFIX = 3'b100;       // CHR space
	localparam logic [8:0] PRG_RAM_PREFIX = 9'b1_1110_0000; // Cartridge RAM

	// Fixed PRG windows
	localparam logic [PRG_BANK_W-1:0] PRG_BANK_LAST        = '1;
	localparam logic [PRG_BANK_W-1:0] PRG_BANK_SECOND_LAST = PRG_BANK_LAST - 1'b1;

	// One CPU bus cycle, as seen by the mapper
	typedef struct packed {
		logic [15:0] addr;  // CPU address
		logic [7:0]  data;  // Write data
		logic        write; // Write strobe, qualified by M2
	} cpu_bus_t;

	// CHR bank registers R0 to R5
	typedef struct packed {
		logic [CHR_BANK_W-2:0] r0; // 2 KB bank, low bit from PPU A10
		logic [CHR_BANK_W-2:0] r1; // 2 KB bank
		logic [CHR_BANK_W-1:0] r2; // 1 KB banks
		logic [CHR_BANK_W-1:0] r3;
		logic [CHR_BANK_W-1:0] r4;
		logic [CHR_BANK_W-1:0] r5;
	} chr_banks_t;

	// PRG bank registers R6, R7 and the window mode
	typedef struct packed {
		logic [PRG_BANK_W-1:0] r6;
		logic [PRG_BANK_W-1:0] r7;
		logic                  prg_mode; // 1 swaps $8000 and $C000 windows
	} prg_banks_t;

	// PRG RAM control from $A001
	typedef struct packed {
		logic ram_enable;
		logic ram_protect; // Blocks writes
	} ram_ctl_t;

	// One-cycle IRQ register strobes
	typedef struct packed {
		logic       latch_we;   // $C000
		logic [7:0] latch_data;
		logic       reload_req; // $C001
		logic       irq_on;     // $E001
		logic       irq_off;    // $E000, also acks
	} irq_ctl_t;

	// Nametable mirroring as written to $A000 bit 0
	typedef enum logic {
		MIRROR_VERTICAL   = 1'b0,
		MIRROR_HORIZONTAL = 1'b1
	} mirror_e;

endpackage

// File: mmc3/mmc3_regs.sv
/* MMC3 register file: CPU write decode into bank select, bank data, mirroring,
   PRG RAM control and the IRQ strobes */
`timescale 1ns/1ps

module mmc3_regs import mmc3_pkg::*; #(
	parameter mirror_e RESET_MIRROR = MIRROR_VERTICAL
) (
	input  logic       clk,
	input  logic       rst_n_i,
	input  logic       ce_i,        // M2 enable
	input  cpu_bus_t   cpu_i,
	output chr_banks_t chr_banks_o,
	output logic       chr_invert_o, // PPU A12 inversion
	output prg_banks_t prg_banks_o,
	output ram_ctl_t   ram_ctl_o,
	output mirror_e    mirror_o,
	output irq_ctl_t   irq_ctl_o
);

	logic       cpu_wr;  // Accepted write into $8000-$FFFF
	logic [2:0] reg_sel; // {A14, A13, A0}
	logic [2:0] bank_sel_q; // Target of next $8001 write

	chr_banks_t chr_banks_q;
	prg_banks_t prg_banks_q;
	ram_ctl_t   ram_ctl_q;
	mirror_e    mirror_q;
	logic       chr_invert_q;

	assign cpu_wr  = ce_i && cpu_i.write && cpu_i.addr[15];
	assign reg_sel = {cpu_i.addr[14:13], cpu_i.addr[0]};

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			bank_sel_q   <= '0;
			chr_banks_q  <= '0;
			prg_banks_q  <= '0;
			ram_ctl_q    <= '0;
			chr_invert_q <= 1'b0;
			mirror_q     <= RESET_MIRROR;
		end else if (cpu_wr) begin
			case (reg_sel)
				3'b00_0: begin // Bank select
					bank_sel_q           <= cpu_i.data[2:0];
					prg_banks_q.prg_mode <= cpu_i.data[6];
					chr_invert_q         <= cpu_i.data[7];
				end
				3'b00_1: begin // Bank data
					case (bank_sel_q)
						3'd0: chr_banks_q.r0 <= cpu_i.data[7:1]; // 2 KB, drop low bit
						3'd1: chr_banks_q.r1 <= cpu_i.data[7:1];
						3'd2: chr_banks_q.r2 <= cpu_i.data;
						3'd3: chr_banks_q.r3 <= cpu_i.data;
						3'd4: chr_banks_q.r4 <= cpu_i.data;
						3'd5: chr_banks_q.r5 <= cpu_i.data;
						3'd6: prg_banks_q.r6 <= cpu_i.data[PRG_BANK_W-1:0];
						default: prg_banks_q.r7 <= cpu_i.data[PRG_BANK_W-1:0]; // R7
					endcase
				end
				3'b01_0: mirror_q <= mirror_e'(cpu_i.data[0]); // 1 is horizontal
				3'b01_1: begin // PRG RAM enable and protect
					ram_ctl_q.ram_enable  <= cpu_i.data[7];
					ram_ctl_q.ram_protect <= cpu_i.data[6];
				end
				default: ; // IRQ regs, decoded below
			endcase
		end
	end

	// IRQ strobes act on the same edge as the write
	always_comb begin
		irq_ctl_o            = '0;
		irq_ctl_o.latch_data = cpu_i.data;
		if (cpu_wr) begin
			case (reg_sel)
				3'b10_0: irq_ctl_o.latch_we   = 1'b1; // $C000
				3'b10_1: irq_ctl_o.reload_req = 1'b1; // $C001
				3'b11_0: irq_ctl_o.irq_off    = 1'b1; // $E000
				3'b11_1: irq_ctl_o.irq_on     = 1'b1; // $E001
				default: ;
			endcase
		end
	end

	assign chr_banks_o  = chr_banks_q;
	assign chr_invert_o = chr_invert_q;
	assign prg_banks_o  = prg_banks_q;
	assign ram_ctl_o    = ram_ctl_q;
	assign mirror_o     = mirror_q;

	// An unknown write qualifier would corrupt the bank state
	a_write_known: assert property (@(posedge clk) disable iff (!rst_n_i)
		!$isunknown({ce_i, cpu_i.write}))
		else $error("CPU write qualifier unknown");

endmodule

// File: mmc3/mmc3_prg_map.sv
/* MMC3 PRG side: 8 KB window to bank translation and PRG RAM decode
   with enable and write protect */
`timescale 1ns/1ps

module mmc3_prg_map import mmc3_pkg::*; (
	input  cpu_bus_t              cpu_i,
	input  prg_banks_t            prg_banks_i,
	input  ram_ctl_t              ram_ctl_i,
	output logic [MAP_ADDR_W-1:0] prg_addr_o,
	output logic                  prg_allow_o  // Access permitted
);

	logic [PRG_BANK_W-1:0] prg_bank;  // Selected 8 KB bank
	logic                  ram_win;   // $6000-$7FFF
	logic                  ram_hit;   // RAM window and enabled
	logic                  ram_ok;    // RAM access allowed
	logic                  rom_ok;    // ROM read

	// Window from A14:A13, mode swaps the $8000 and $C000 sources
	always_comb begin
		case (cpu_i.addr[14:13])
			2'b00: begin
				if (prg_banks_i.prg_mode)
					prg_bank = PRG_BANK_SECOND_LAST;
				else
					prg_bank = prg_banks_i.r6;
			end
			2'b01: prg_bank = prg_banks_i.r7; // Same in both modes
			2'b10: begin
				if (prg_banks_i.prg_mode)
					prg_bank = prg_banks_i.r6;
				else
					prg_bank = PRG_BANK_SECOND_LAST;
			end
			default: prg_bank = PRG_BANK_LAST; // $E000 always fixed
		endcase
	end

	assign ram_win = (cpu_i.addr[15:13] == 3'b011);
	assign ram_hit = ram_win && ram_ctl_i.ram_enable;
	assign ram_ok  = ram_hit && !(cpu_i.write && ram_ctl_i.ram_protect);
	assign rom_ok  = cpu_i.addr[15] && !cpu_i.write; // Writes there hit registers

	always_comb begin
		if (ram_hit)
			prg_addr_o = {PRG_RAM_PREFIX, cpu_i.addr[12:0]};
		else
			prg_addr_o = {PRG_ROM_PREFIX, prg_bank, cpu_i.addr[12:0]};
	end

	assign prg_allow_o = rom_ok || ram_ok;

endmodule

// File: mmc3/mmc3_chr_map.sv
/* MMC3 CHR side: 1 KB and 2 KB bank translation with A12 inversion,
   nametable A10 and VRAM select */
`timescale 1ns/1ps

module mmc3_chr_map import mmc3_pkg::*; (
	input  logic [13:0]           ppu_addr_i,
	input  chr_banks_t            chr_banks_i,
	input  logic                  chr_invert_i,
	input  mirror_e               mirror_i,
	output logic [MAP_ADDR_W-1:0] chr_addr_o,
	output logic                  vram_a10_o,  // CIRAM A10
	output logic                  vram_ce_o    // Internal 2 KB VRAM select
);

	logic                  half_sel; // A12 after inversion
	logic [CHR_BANK_W-1:0] chr_bank; // 1 KB bank number

	assign half_sel = ppu_addr_i[12] ^ chr_invert_i;

	always_comb begin
		if (!half_sel) begin
			// 2 KB halves, A10 picks the 1 KB page
			if (ppu_addr_i[11])
				chr_bank = {chr_banks_i.r1, ppu_addr_i[10]};
			else
				chr_bank = {chr_banks_i.r0, ppu_addr_i[10]};
		end else begin
			case (ppu_addr_i[11:10])
				2'b00:   chr_bank = chr_banks_i.r2;
				2'b01:   chr_bank = chr_banks_i.r3;
				2'b10:   chr_bank = chr_banks_i.r4;
				default: chr_bank = chr_banks_i.r5;
			endcase
		end
	end

	// Spare bit between prefix and bank keeps the 22-bit layout
	assign chr_addr_o = {CHR_ROM_PREFIX, 1'b0, chr_bank, ppu_addr_i[9:0]};

	always_comb begin
		if (mirror_i == MIRROR_VERTICAL)
			vram_a10_o = ppu_addr_i[10];
		else
			vram_a10_o = ppu_addr_i[11]; // Horizontal
	end

	assign vram_ce_o = ppu_addr_i[13]; // Nametables at $2000 and up

endmodule

// File: mmc3/mmc3_irq_counter.sv
/* MMC3 scanline IRQ: PPU A12 low-time filter, reloadable 8-bit counter
   and IRQ flag with old or new zero behavior */
`timescale 1ns/1ps

module mmc3_irq_counter import mmc3_pkg::*; #(
	parameter int A12_LOW_CYCLES = 15, // M2 cycles A12 must stay low
	parameter bit ALT_IRQ        = 0   // 1 selects the old behavior
) (
	input  logic     clk,
	input  logic     rst_n_i,
	input  logic     ce_i,
	input  logic     ppu_a12_i,
	input  irq_ctl_t irq_ctl_i,
	output logic     irq_o
);

	localparam int FILT_W = $clog2(A12_LOW_CYCLES + 1);

	logic [FILT_W-1:0] filt_q;    // A12 low-time filter
	logic [7:0]        latch_q;
	logic [7:0]        count_q;
	logic              reload_q;  // Reload pending
	logic              enable_q;
	logic              irq_q;

	logic       a12_event;        // Filtered rising edge
	logic [7:0] count_nxt;
	logic       irq_hit;

	assign a12_event = ce_i && ppu_a12_i && (filt_q == '0);
	assign count_nxt = (count_q == 8'd0 || reload_q) ? latch_q : count_q - 8'd1;

	// Old chips only fire on a transition to zero
	assign irq_hit = (count_nxt == 8'd0) && enable_q &&
		(!ALT_IRQ || count_q != 8'd0 || reload_q);

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			filt_q <= '0;
		end else if (ce_i) begin
			if (ppu_a12_i)
				filt_q <= FILT_W'(A12_LOW_CYCLES);
			else if (filt_q != '0)
				filt_q <= filt_q - FILT_W'(1);
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			latch_q  <= '0;
			count_q  <= '0;
			reload_q <= 1'b0;
			enable_q <= 1'b0;
			irq_q    <= 1'b0;
		end else begin
			if (a12_event) begin
				count_q  <= count_nxt;
				reload_q <= 1'b0;
				if (irq_hit)
					irq_q <= 1'b1;
			end
			// Register writes win over a same-cycle event
			if (irq_ctl_i.latch_we)
				latch_q <= irq_ctl_i.latch_data;
			if (irq_ctl_i.reload_req)
				reload_q <= 1'b1;
			if (irq_ctl_i.irq_on)
				enable_q <= 1'b1;
			if (irq_ctl_i.irq_off) begin
				enable_q <= 1'b0;
				irq_q    <= 1'b0; // Also acknowledges
			end
		end
	end

	assign irq_o = irq_q;

	// Filter counts M2 cycles, so ce_i lasts one clk
	a_ce_single_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
		ce_i |=> !ce_i)
		else $error("M2 enable held for more than one clk cycle");

endmodule

// File: src/mmc3_top.sv
/* MMC3 mapper top: register block beside the PRG, CHR and IRQ datapaths */
`timescale 1ns/1ps

module mmc3_top import mmc3_pkg::*; #(
	parameter int      A12_LOW_CYCLES = 15,
	parameter bit      ALT_IRQ        = 0,
	parameter mirror_e RESET_MIRROR   = MIRROR_VERTICAL
) (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic                  ce_i,        // M2 enable
	input  cpu_bus_t              cpu_i,
	input  logic [13:0]           ppu_addr_i,
	input  logic                  ppu_a12_i,   // Raw A12 for the counter
	output logic [MAP_ADDR_W-1:0] prg_addr_o,
	output logic                  prg_allow_o,
	output logic [MAP_ADDR_W-1:0] chr_addr_o,
	output logic                  vram_a10_o,
	output logic                  vram_ce_o,
	output logic                  irq_o
);

	chr_banks_t chr_banks;
	prg_banks_t prg_banks;
	ram_ctl_t   ram_ctl;
	mirror_e    mirror;
	irq_ctl_t   irq_ctl;
	logic       chr_invert;

	mmc3_regs #(.RESET_MIRROR(RESET_MIRROR)) u_regs (
		.clk(clk), .rst_n_i(rst_n_i), .ce_i(ce_i), .cpu_i(cpu_i),
		.chr_banks_o(chr_banks), .chr_invert_o(chr_invert),
		.prg_banks_o(prg_banks), .ram_ctl_o(ram_ctl),
		.mirror_o(mirror), .irq_ctl_o(irq_ctl)
	);

	mmc3_prg_map u_prg_map (
		.cpu_i(cpu_i), .prg_banks_i(prg_banks), .ram_ctl_i(ram_ctl),
		.prg_addr_o(prg_addr_o), .prg_allow_o(prg_allow_o)
	);

	mmc3_chr_map u_chr_map (
		.ppu_addr_i(ppu_addr_i), .chr_banks_i(chr_banks),
		.chr_invert_i(chr_invert), .mirror_i(mirror),
		.chr_addr_o(chr_addr_o), .vram_a10_o(vram_a10_o), .vram_ce_o(vram_ce_o)
	);

	mmc3_irq_counter #(
		.A12_LOW_CYCLES(A12_LOW_CYCLES),
		.ALT_IRQ(ALT_IRQ)
	) u_irq (
		.clk(clk), .rst_n_i(rst_n_i), .ce_i(ce_i), .ppu_a12_i(ppu_a12_i),
		.irq_ctl_i(irq_ctl), .irq_o(irq_o)
	);

endmodule

// File: verification/mmc3_tb.sv
/* MMC3 mapper testbench: clock, reset, CPU write and PPU A12 stimulus,
   a table of writes, probes and expected values, and a cycle timeout */
`timescale 1ns/1ps

module mmc3_tb import mmc3_pkg::*; ();

	typedef enum logic [3:0] {
		OP_WR, OP_PRG, OP_ALLOW, OP_CHR, OP_A10, OP_VCE, OP_PULSE, OP_IRQ, OP_END
	} op_e;

	typedef struct packed {
		op_e         op;
		logic [15:0] addr; // CPU or PPU address
		logic [7:0]  data; // Write data, pulse count or test index
		logic [21:0] exp;  // Expected output
	} step_t;

	logic                  clk = 1'b0;
	logic                  rst_n_i;
	logic                  ce_i;
	cpu_bus_t              cpu_i;
	logic [13:0]           ppu_addr_i;
	logic                  ppu_a12_i;
	logic [MAP_ADDR_W-1:0] prg_addr_o;
	logic                  prg_allow_o;
	logic [MAP_ADDR_W-1:0] chr_addr_o;
	logic                  vram_a10_o;
	logic                  vram_ce_o;
	logic                  irq_o;

	step_t steps[$];
	string test_names[6];
	logic [1:0] ce_cnt = 2'd0; // M2 phase
	int cycles      = 0;
	int cycle_limit = 0;
	int checks      = 0;
	int errors      = 0;
	int tests_run   = 0;
	int tests_failed = 0;
	int test_err_start = 0;

	mmc3_top #(.RESET_MIRROR(MIRROR_VERTICAL)) DUT (
		.clk(clk), .rst_n_i(rst_n_i), .ce_i(ce_i), .cpu_i(cpu_i),
		.ppu_addr_i(ppu_addr_i), .ppu_a12_i(ppu_a12_i),
		.prg_addr_o(prg_addr_o), .prg_allow_o(prg_allow_o),
		.chr_addr_o(chr_addr_o), .vram_a10_o(vram_a10_o),
		.vram_ce_o(vram_ce_o), .irq_o(irq_o)
	);

	initial begin
		forever #4 clk = ~clk; // 8 ns period
	end

	always @(posedge clk) begin
		ce_cnt <= ce_cnt + 2'd1;
		ce_i   <= (ce_cnt == 2'd2); // High one cycle in four
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// Expected addresses, built from the mapped address layout
	function automatic logic [21:0] prg_rom_addr(input logic [5:0] bank, input logic [12:0] off);
		return {3'b000, bank, off};
	endfunction

	function automatic logic [21:0] chr_rom_addr(input logic [7:0] bank, input logic [9:0] off);
		return {3'b100, 1'b0, bank, off}; // Prefix at the top, spare bit zero
	endfunction

	function automatic logic [21:0] ram_addr(input logic [12:0] off);
		return {9'b1_1110_0000, off};
	endfunction

	task automatic add_step(input op_e op, input logic [15:0] addr, input logic [7:0] data,
			input logic [21:0] exp);
		step_t s;
		s.op   = op;
		s.addr = addr;
		s.data = data;
		s.exp  = exp;
		steps.push_back(s);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	// Returns just after the n-th edge on which the DUT saw ce_i high
	task automatic wait_ce(input int n);
		repeat (n) begin
			do @(posedge clk); while (!ce_i);
		end
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk);
		cpu_i <= {addr, data, 1'b1};
		wait_ce(1);                   // Accepted on this edge
		cpu_i <= {addr, data, 1'b0};
	endtask

	task automatic cpu_access(input logic [15:0] addr, input logic wr);
		@(posedge clk);
		cpu_i <= {addr, 8'h00, wr};
		@(negedge clk);               // Combinational outputs settled
	endtask

	task automatic ppu_probe(input logic [13:0] addr);
		@(posedge clk);
		ppu_addr_i <= addr;
		@(negedge clk);
	endtask

	task automatic a12_pulses(input int n);
		repeat (n) begin
			@(posedge clk);
			ppu_a12_i <= 1'b1;
			wait_ce(2);
			ppu_a12_i <= 1'b0;
			wait_ce(20);              // Long enough to pass the filter
		end
	endtask

	task automatic build_table();
		logic [7:0] chr_vals[6];
		logic [7:0] plain_banks[8];
		logic [7:0] inv_banks[8];
		int k;
		chr_vals    = '{8'h11, 8'h23, 8'h30, 8'h41, 8'h52, 8'hFF};
		plain_banks = '{8'h10, 8'h11, 8'h22, 8'h23, 8'h30, 8'h41, 8'h52, 8'hFF};
		inv_banks   = '{8'h30, 8'h41, 8'h52, 8'hFF, 8'h10, 8'h11, 8'h22, 8'h23};
		// Reset state
		add_step(OP_IRQ, 16'h0000, 8'h00, 22'd0);
		add_step(OP_A10, 16'h0400, 8'h00, 22'd1);
		add_step(OP_A10, 16'h0800, 8'h00, 22'd0);
		add_step(OP_PRG, 16'hE123, 8'h00, prg_rom_addr(6'h3F, 13'h0123));
		add_step(OP_END, 16'h0000, 8'd0, 22'd0);
		// PRG banking, R6 = 5 and R7 = 10
		add_step(OP_WR, 16'h8000, 8'h06, 22'd0);
		add_step(OP_WR, 16'h8001, 8'h05, 22'd0);
		add_step(OP_WR, 16'h8000, 8'h07, 22'd0);
		add_step(OP_WR, 16'h8001, 8'h0A, 22'd0);
		add_step(OP_PRG, 16'h8000, 8'h00, prg_rom_addr(6'h05, 13'h0000));
		add_step(OP_PRG, 16'hA010, 8'h00, prg_rom_addr(6'h0A, 13'h0010));
		add_step(OP_PRG, 16'hC100, 8'h00, prg_rom_addr(6'h3E, 13'h0100));
		add_step(OP_PRG, 16'hFFFF, 8'h00, prg_rom_addr(6'h3F, 13'h1FFF));
		add_step(OP_WR, 16'h8000, 8'h40, 22'd0); // Mode 1
		add_step(OP_PRG, 16'h8000, 8'h00, prg_rom_addr(6'h3E, 13'h0000));
		add_step(OP_PRG, 16'hA010, 8'h00, prg_rom_addr(6'h0A, 13'h0010));
		add_step(OP_PRG, 16'hC100, 8'h00, prg_rom_addr(6'h05, 13'h0100));
		add_step(OP_PRG, 16'hFFFF, 8'h00, prg_rom_addr(6'h3F, 13'h1FFF));
		add_step(OP_END, 16'h0000, 8'd1, 22'd0);
		// CHR banking, R0 and R1 drop data bit 0
		for (k = 0; k < 6; k++) begin
			add_step(OP_WR, 16'h8000, 8'(k), 22'd0);
			add_step(OP_WR, 16'h8001, chr_vals[k], 22'd0);
		end
		for (k = 0; k < 8; k++)
			add_step(OP_CHR, 16'(k * 16'h0400 + k), 8'h00, chr_rom_addr(plain_banks[k], 10'(k)));
		add_step(OP_WR, 16'h8000, 8'h80, 22'd0); // Swap the pattern halves
		for (k = 0; k < 8; k++)
			add_step(OP_CHR, 16'(k * 16'h0400 + k), 8'h00, chr_rom_addr(inv_banks[k], 10'(k)));
		add_step(OP_END, 16'h0000, 8'd2, 22'd0);
		// Horizontal mirroring and VRAM select
		add_step(OP_WR, 16'hA000, 8'h01, 22'd0);
		add_step(OP_A10, 16'h2400, 8'h00, 22'd0);
		add_step(OP_A10, 16'h2800, 8'h00, 22'd1);
		add_step(OP_VCE, 16'h2000, 8'h00, 22'd1);
		add_step(OP_VCE, 16'h1FFF, 8'h00, 22'd0);
		add_step(OP_END, 16'h0000, 8'd3, 22'd0);
		// PRG RAM, data bit 0 of an access step is the write flag
		add_step(OP_ALLOW, 16'h6000, 8'h00, 22'd0);
		add_step(OP_WR, 16'hA001, 8'h80, 22'd0);
		add_step(OP_ALLOW, 16'h6000, 8'h00, 22'd1);
		add_step(OP_PRG, 16'h6010, 8'h00, ram_addr(13'h0010));
		add_step(OP_WR, 16'hA001, 8'hC0, 22'd0); // Protect
		add_step(OP_ALLOW, 16'h6000, 8'h01, 22'd0);
		add_step(OP_ALLOW, 16'h6000, 8'h00, 22'd1);
		add_step(OP_END, 16'h0000, 8'd4, 22'd0);
		// Scanline IRQ with latch 3
		add_step(OP_WR, 16'hC000, 8'h03, 22'd0);
		add_step(OP_WR, 16'hC001, 8'h00, 22'd0);
		add_step(OP_WR, 16'hE001, 8'h00, 22'd0);
		add_step(OP_PULSE, 16'h0000, 8'd3, 22'd0);
		add_step(OP_IRQ, 16'h0000, 8'h00, 22'd0);
		add_step(OP_PULSE, 16'h0000, 8'd1, 22'd0);
		add_step(OP_IRQ, 16'h0000, 8'h00, 22'd1);
		add_step(OP_WR, 16'hE000, 8'h00, 22'd0); // Ack and disable
		add_step(OP_IRQ, 16'h0000, 8'h00, 22'd0);
		add_step(OP_PULSE, 16'h0000, 8'd5, 22'd0);
		add_step(OP_IRQ, 16'h0000, 8'h00, 22'd0);
		add_step(OP_END, 16'h0000, 8'd5, 22'd0);
	endtask

	task automatic run_step(input step_t s);
		case (s.op)
			OP_WR: cpu_write(s.addr, s.data);
			OP_PRG: begin
				cpu_access(s.addr, 1'b0);
				check_value("prg_addr_o", 32'(prg_addr_o), 32'(s.exp));
			end
			OP_ALLOW: begin
				cpu_access(s.addr, s.data[0]);
				check_value("prg_allow_o", 32'(prg_allow_o), 32'(s.exp[0]));
			end
			OP_CHR: begin
				ppu_probe(s.addr[13:0]);
				check_value("chr_addr_o", 32'(chr_addr_o), 32'(s.exp));
			end
			OP_A10: begin
				ppu_probe(s.addr[13:0]);
				check_value("vram_a10_o", 32'(vram_a10_o), 32'(s.exp[0]));
			end
			OP_VCE: begin
				ppu_probe(s.addr[13:0]);
				check_value("vram_ce_o", 32'(vram_ce_o), 32'(s.exp[0]));
			end
			OP_PULSE: a12_pulses(int'(s.data));
			OP_IRQ: begin
				@(negedge clk);
				check_value("irq_o", 32'(irq_o), 32'(s.exp[0]));
			end
			default: begin // End of one test
				tests_run++;
				if (errors > test_err_start)
					tests_failed++;
				$display("Test %0d %s: %s (%0d mismatches)", s.data, test_names[s.data],
					(errors > test_err_start) ? "failed" : "passed", errors - test_err_start);
				test_err_start = errors;
			end
		endcase
	endtask

	initial begin
		rst_n_i    = 1'b0;
		ce_i       = 1'b0;
		cpu_i      = '0;
		ppu_addr_i = '0;
		ppu_a12_i  = 1'b0;
		test_names[0] = "reset state";
		test_names[1] = "PRG banking";
		test_names[2] = "CHR banking";
		test_names[3] = "mirroring";
		test_names[4] = "PRG RAM";
		test_names[5] = "scanline IRQ";
		build_table();
		cycle_limit = 200 * steps.size();
		repeat (4) @(posedge clk);
		rst_n_i <= 1'b1;
		for (int i = 0; i < steps.size(); i++)
			run_step(steps[i]);
		$display("Tests run %0d, failed %0d, checks %0d, mismatches %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0 && tests_failed == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: vlog.f
common/mmc3_pkg.sv
mmc3/mmc3_regs.sv
mmc3/mmc3_prg_map.sv
mmc3/mmc3_chr_map.sv
mmc3/mmc3_irq_counter.sv
src/mmc3_top.sv
verification/mmc3_tb.sv
